//--- Makefile
VERILATOR ?= verilator
TOP       ?= tag_mem_tb
FILELIST  ?= tag_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tag_mem.f
+incdir+verilog
verilog/cmd_pkg.sv
verilog/mem_pkg.sv
verilog/tag_mem_ifs.sv
verilog/sensor_request.sv
verilog/mem_sequencer.sv
verilog/tx_serializer.sv
verilog/tag_mem_top.sv
verification/tag_mem_tb.sv

//--- verification/tag_mem_tb.sv
`timescale 1ns/1ps
`include "tag_mem_defines.svh"

module tag_mem_tb
    import cmd_pkg::*;
    import mem_pkg::*;
();

    localparam int NUM_SAMPLES    = 14;
    localparam int NUM_WORDS      = 12;
    localparam int TIMEOUT_CYCLES = NUM_SAMPLES * 20 + NUM_WORDS * 16 * 4 + 200;

    logic                  clk;
    logic                  reset;
    logic                  adc_data_ready;
    logic [`TAG_ADC_W-1:0] adc_data;
    logic [`TAG_TS_W-1:0]  sensor_time_stamp;
    sensor_t               sensor_code;
    logic                  sensor_read;
    logic                  bit_tick;
    word_t                 mem_read_in;
    word_t                 mem_data_out;
    logic                  pc_b;
    logic                  we;
    logic                  se;
    logic                  mem_done;
    addr_t                 mem_address;
    bank_t                 mem_sel;
    logic                  tx_bit_src;
    logic                  tx_data_done;

    word_t       mem_s1 [`TAG_BANK_DEPTH];
    word_t       mem_s2 [`TAG_BANK_DEPTH];
    word_t       exp_s1 [$];    // oldest first
    word_t       exp_s2 [$];
    word_t       rd_exp [$];
    logic [31:0] lfsr = 32'h9752cdde;
    int          errors = 0;
    int          checks = 0;
    int          test_num = 1;
    int          test_errors = 0;
    int          cycles = 0;
    int          writes_seen = 0;
    logic        collecting;
    logic        tick_q = 1'b0;
    word_t       rx_word = '0;
    int          rx_bits = 0;
    int          total_bits = 0;

    tag_mem_top u_tag_mem_top (
        .clk (clk), .reset (reset), .adc_data_ready (adc_data_ready), .adc_data (adc_data),
        .sensor_time_stamp (sensor_time_stamp), .sensor_code (sensor_code),
        .sensor_read (sensor_read), .bit_tick (bit_tick), .mem_read_in (mem_read_in),
        .mem_data_out (mem_data_out), .pc_b (pc_b), .we (we), .se (se),
        .mem_address (mem_address), .mem_sel (mem_sel), .mem_done (mem_done),
        .tx_bit_src (tx_bit_src), .tx_data_done (tx_data_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // memory array model
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TAG_BANK_DEPTH; i++) begin
                mem_s1[i] <= (word_t'(i) * 16'h0203) ^ 16'h5a3c;
                mem_s2[i] <= (word_t'(i) * 16'h0203) ^ 16'hc3a5;
            end
        end else if (we && mem_done) begin
            if (mem_sel == BANK_S2) mem_s2[mem_address] <= mem_data_out;
            else mem_s1[mem_address] <= mem_data_out;
            writes_seen <= writes_seen + 1;
        end
    end

    assign mem_read_in = !se ? '0 :
                         (mem_sel == BANK_S2) ? mem_s2[mem_address] : mem_s1[mem_address];

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // x^32+x^22+x^2+x+1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
    endtask

    // stamp in the upper byte, adc value below
    function automatic word_t ref_word(input logic [`TAG_TS_W-1:0] stamp,
                                       input logic [`TAG_ADC_W-1:0] value);
        return {stamp, value};
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bank(input bank_t got_sel, input addr_t got_addr,
                              input bank_t exp_sel, input addr_t exp_addr, input string what);
        checks++;
        if (got_sel !== exp_sel || got_addr !== exp_addr) begin
            errors++;
            test_errors++;
            $display("FAIL %0t: %s got bank %0d addr %0d expected bank %0d addr %0d",
                     $time, what, got_sel, got_addr, exp_sel, exp_addr);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) $display("test %0d %s: ok", test_num, name);
        else $display("test %0d %s: %0d errors", test_num, name, test_errors);
        test_num++;
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////
    // serial monitor, compares newest word first
    //////////////////////////////////////////////////

    always @(posedge clk) tick_q <= bit_tick && collecting;

    always @(negedge clk) begin
        if (tick_q) begin
            rx_word    = {tx_bit_src, rx_word[`TAG_WORD_W-1:1]};    // lsb arrives first
            rx_bits    = rx_bits + 1;
            total_bits = total_bits + 1;
            if (rx_bits == `TAG_WORD_W) begin
                rx_bits = 0;
                if (rd_exp.size() == 0) begin
                    errors++;
                    test_errors++;
                    $display("unexpected extra word %h on tx_bit_src at %0t", rx_word, $time);
                end else begin
                    check_word(rx_word, rd_exp.pop_back(), "serial word");
                end
            end
        end
    end

    task automatic send_sample(input sensor_t code, input logic expect_write, input logic collide);
        logic [31:0]           r;
        logic [`TAG_ADC_W-1:0] value;
        logic [`TAG_TS_W-1:0]  stamp;
        int                    cyc;
        int                    wr_before;
        addr_t                 exp_addr;
        rand_bits(`TAG_ADC_W, r);
        value = r[`TAG_ADC_W-1:0];
        rand_bits(`TAG_TS_W, r);
        stamp     = r[`TAG_TS_W-1:0];
        exp_addr  = (code == SENSOR_2) ? addr_t'(exp_s2.size()) : addr_t'(exp_s1.size());
        wr_before = writes_seen;
        adc_data_ready    = 1'b1;
        sensor_code       = code;
        adc_data          = value;
        sensor_time_stamp = stamp;
        @(negedge clk);
        cyc = 0;
        if (collide) begin
            sensor_code       = SENSOR_2;    // lands on the pending write
            adc_data          = ~value;
            sensor_time_stamp = ~stamp;
            @(negedge clk);
            cyc = 1;
        end
        adc_data_ready = 1'b0;
        sensor_code    = SENSOR_NONE;
        while (!mem_done && cyc < 12) begin
            @(negedge clk);
            cyc++;
        end
        if (expect_write) begin
            check_flag(mem_done, 1'b1, "mem_done after sample");
            check_flag(cyc == 6, 1'b1, "mem_done 6 cycles after adc_data_ready");
            check_bank(mem_sel, mem_address, (code == SENSOR_2) ? BANK_S2 : BANK_S1, exp_addr,
                       "write target");
            check_word(mem_data_out, ref_word(stamp, value), "mem_data_out");
            if (code == SENSOR_2) exp_s2.push_back(ref_word(stamp, value));
            else exp_s1.push_back(ref_word(stamp, value));
        end else begin
            check_flag(mem_done, 1'b0, "mem_done for dropped sample");
        end
        repeat (6) @(negedge clk);    // request retires
        check_flag((writes_seen - wr_before) == (expect_write ? 1 : 0), 1'b1, "array writes");
    endtask

    task automatic read_sensor(input sensor_t code, input logic random_gap);
        logic [31:0] r;
        int          n;
        int          gap;
        int          bits_before;
        logic        stray;
        if (code == SENSOR_2) begin
            rd_exp = exp_s2;
            exp_s2.delete();
        end else begin
            rd_exp = exp_s1;
            exp_s1.delete();
        end
        n           = rd_exp.size();
        bits_before = total_bits;
        sensor_read = 1'b1;
        sensor_code = code;
        @(negedge clk);
        sensor_read = 1'b0;
        sensor_code = SENSOR_NONE;
        if (n == 0) begin
            stray    = 1'b0;
            bit_tick = 1'b1;
            repeat (12) begin
                @(negedge clk);
                stray = stray | se | !tx_data_done;
            end
            bit_tick = 1'b0;
            @(negedge clk);
            check_flag(stray, 1'b0, "se or tx_data_done change on empty read");
        end else begin
            while (!se) @(negedge clk);
            while (se) @(negedge clk);    // first word now in the serializer
            collecting = 1'b1;
            while (!tx_data_done) begin
                bit_tick = 1'b1;
                @(negedge clk);
                gap = 1;
                if (random_gap) begin
                    rand_bits(2, r);
                    gap = int'(r[1:0]) + 1;
                end
                if (gap > 1) begin
                    bit_tick = 1'b0;
                    repeat (gap - 1) @(negedge clk);
                end
            end
            bit_tick   = 1'b0;
            collecting = 1'b0;
            @(negedge clk);
            check_flag((total_bits - bits_before) == n * `TAG_WORD_W, 1'b1, "bits in read");
            check_flag(rd_exp.size() == 0, 1'b1, "all stored words sent");
        end
    endtask

    initial begin
        reset             = 1'b1;
        adc_data_ready    = 1'b0;
        adc_data          = '0;
        sensor_time_stamp = '0;
        sensor_code       = SENSOR_NONE;
        sensor_read       = 1'b0;
        bit_tick          = 1'b0;
        collecting        = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag(pc_b, 1'b1, "pc_b after reset");
        check_flag(we | se | mem_done | tx_data_done, 1'b0, "strobes after reset");
        check_flag(mem_sel == BANK_NONE, 1'b1, "mem_sel after reset");
        finish_test("reset values");
        send_sample(SENSOR_1, 1'b1, 1'b0);
        finish_test("single sample timing");
        for (int i = 0; i < 5; i++) begin
            send_sample(SENSOR_1, 1'b1, 1'b0);
            send_sample(SENSOR_2, 1'b1, 1'b0);
        end
        finish_test("interleaved samples");
        read_sensor(SENSOR_2, 1'b0);
        read_sensor(SENSOR_2, 1'b0);    // bank now empty
        finish_test("sensor 2 read");
        send_sample(sensor_t'(3'd5), 1'b0, 1'b0);
        send_sample(SENSOR_NONE, 1'b0, 1'b0);
        send_sample(SENSOR_1, 1'b1, 1'b1);
        finish_test("dropped samples");
        read_sensor(SENSOR_1, 1'b1);
        finish_test("random bit_tick read");
        $display("%0d tests, %0d checks, %0d errors", test_num - 1, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog/cmd_pkg.sv
`include "tag_mem_defines.svh"

package cmd_pkg;

    //////////////////////////////////////////////////
    // front end requests and the stored word
    //////////////////////////////////////////////////

    typedef logic [`TAG_WORD_W-1:0] word_t;

    // 3-bit code from the ADC mux
    typedef enum logic [2:0] {
        SENSOR_NONE = 3'd0,
        SENSOR_1    = 3'd1,
        SENSOR_2    = 3'd2
    } sensor_t;

    // time stamp on top, adc value below
    typedef struct packed {
        logic [`TAG_TS_W-1:0]  stamp;
        logic [`TAG_ADC_W-1:0] value;
    } sample_t;

endpackage

//--- verilog/mem_pkg.sv
`include "tag_mem_defines.svh"

package mem_pkg;

    //////////////////////////////////////////////////
    // memory array side
    //////////////////////////////////////////////////

    typedef logic [`TAG_ADDR_W-1:0] addr_t;

    // mem_sel encoding of the array
    typedef enum logic [1:0] {
        BANK_NONE = 2'd0,
        BANK_EPC  = 2'd1,    // epc bank, not driven here
        BANK_S1   = 2'd2,
        BANK_S2   = 2'd3
    } bank_t;

    // one cycle per strobe step
    typedef enum logic [2:0] {
        IDLE,
        SEL,
        PRECHARGE,
        ADDR,
        STROBE,
        DATA,
        RELEASE
    } seq_state_t;

endpackage

//--- verilog/mem_sequencer.sv
`timescale 1ns/1ps
`include "tag_mem_defines.svh"

module mem_sequencer
    import cmd_pkg::*;
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    request_if.sink  req,
    word_if.source   tx,
    input  word_t    mem_read_in,
    output word_t    mem_data_out,
    output logic     pc_b,
    output logic     we,
    output logic     se,
    output logic     mem_done,
    output addr_t    mem_address,
    output bank_t    mem_sel
);

    seq_state_t  state;
    logic        rd_active;     // read in progress, spans several words
    logic        done_q;
    logic        load_q;
    logic        last_q;
    word_t       word_q;
    addr_t [1:0] fill;          // fill counters, index 1 is sensor 2
    logic        bank_idx;
    addr_t       cur_count;
    logic        bank_full;

    function automatic bank_t bank_of(input sensor_t s);
        return (s == SENSOR_2) ? BANK_S2 : BANK_S1;
    endfunction

    assign bank_idx  = (req.sensor == SENSOR_2);
    assign cur_count = fill[bank_idx];
    assign bank_full = (cur_count == addr_t'(`TAG_BANK_DEPTH));

    assign req.done = done_q;
    assign tx.load  = load_q;
    assign tx.word  = word_q;
    assign tx.last  = last_q;

    //////////////////////////////////////////////////
    // strobe sequence, shared by reads and writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            rd_active <= 1'b0;
            done_q    <= 1'b0;
            load_q    <= 1'b0;
            last_q    <= 1'b0;
            pc_b      <= 1'b1;
            we        <= 1'b0;
            se        <= 1'b0;
            mem_done  <= 1'b0;
            mem_sel   <= BANK_NONE;
            fill      <= '0;
        end else begin
            done_q <= 1'b0;
            load_q <= 1'b0;
            case (state)
                IDLE: begin
                    // hold off while the front end drops its pending level
                    if (!done_q) begin
                        if (rd_active) begin
                            if (tx.next_word) begin
                                state <= SEL;
                            end
                        end else if (req.wr_pend) begin
                            state <= SEL;
                        end else if (req.rd_pend) begin
                            if (cur_count == '0) begin
                                done_q <= 1'b1;    // nothing stored
                            end else begin
                                rd_active <= 1'b1;
                                state     <= SEL;
                            end
                        end
                    end
                end
                SEL: begin
                    mem_sel <= bank_of(req.sensor);
                    state   <= PRECHARGE;
                end
                PRECHARGE: begin
                    pc_b  <= 1'b0;
                    state <= ADDR;
                end
                ADDR: begin
                    state <= STROBE;
                end
                STROBE: begin
                    if (rd_active) begin
                        se <= 1'b1;
                    end else begin
                        we <= !bank_full;
                    end
                    state <= DATA;
                end
                DATA: begin
                    if (rd_active) begin
                        load_q         <= 1'b1;
                        last_q         <= (cur_count == addr_t'(1));
                        fill[bank_idx] <= cur_count - addr_t'(1);
                    end else if (!bank_full) begin
                        mem_done       <= 1'b1;
                        fill[bank_idx] <= cur_count + addr_t'(1);
                    end
                    state <= RELEASE;
                end
                RELEASE: begin
                    pc_b     <= 1'b1;
                    we       <= 1'b0;
                    se       <= 1'b0;
                    mem_done <= 1'b0;
                    mem_sel  <= BANK_NONE;
                    if (!rd_active || last_q) begin
                        done_q    <= 1'b1;
                        rd_active <= 1'b0;
                    end
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address and data paths
    always_ff @(posedge clk) begin
        if (state == ADDR) begin
            mem_address <= rd_active ? cur_count - addr_t'(1) : cur_count;    // newest first
        end
        if (state == STROBE && !rd_active) begin
            mem_data_out <= word_t'(req.wr_data);
        end
        if (state == DATA && rd_active) begin
            word_q <= mem_read_in;
        end
    end

endmodule

//--- verilog/sensor_request.sv
`timescale 1ns/1ps
`include "tag_mem_defines.svh"

module sensor_request
    import cmd_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  adc_data_ready,
    input  logic [`TAG_ADC_W-1:0] adc_data,
    input  logic [`TAG_TS_W-1:0]  sensor_time_stamp,
    input  sensor_t               sensor_code,
    input  logic                  sensor_read,
    request_if.source             req
);

    logic code_ok;
    logic busy;
    logic take_wr;
    logic take_rd;

    assign code_ok = (sensor_code == SENSOR_1) || (sensor_code == SENSOR_2);
    assign busy    = req.wr_pend || req.rd_pend;

    // a sample beats a read command in the same cycle
    assign take_wr = adc_data_ready && code_ok && !busy;
    assign take_rd = sensor_read && code_ok && !busy && !take_wr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req.wr_pend <= 1'b0;
            req.rd_pend <= 1'b0;
            req.sensor  <= SENSOR_NONE;
        end else begin
            if (req.done) begin
                req.wr_pend <= 1'b0;
                req.rd_pend <= 1'b0;
            end else if (take_wr) begin
                req.wr_pend <= 1'b1;
                req.sensor  <= sensor_code;
            end else if (take_rd) begin
                req.rd_pend <= 1'b1;
                req.sensor  <= sensor_code;
            end
        end
    end

    // sample and stamp packed into one word
    always_ff @(posedge clk) begin
        if (take_wr) begin
            req.wr_data.stamp <= sensor_time_stamp;
            req.wr_data.value <= adc_data;
        end
    end

endmodule

//--- verilog/tag_mem_defines.svh
`ifndef TAG_MEM_DEFINES_SVH
`define TAG_MEM_DEFINES_SVH

// memory array geometry
`define TAG_WORD_W      16
`define TAG_ADDR_W      6
`define TAG_BANK_DEPTH  63    // words per sensor bank, full bank drops samples

// sample fields
`define TAG_ADC_W       8
`define TAG_TS_W        8

// bit of the current word at which the next one is requested
`define TAG_NEXT_BIT    2

`endif

//--- verilog/tag_mem_ifs.sv
`timescale 1ns/1ps

//////////////////////////////////////////////////
// pending requests, front end to sequencer
//////////////////////////////////////////////////

interface request_if
    import cmd_pkg::*;
();
    logic    wr_pend;    // held until done
    logic    rd_pend;
    sensor_t sensor;
    sample_t wr_data;
    logic    done;       // one cycle, ends the request

    modport source (
        output wr_pend,
        output rd_pend,
        output sensor,
        output wr_data,
        input  done
    );

    modport sink (
        input  wr_pend,
        input  rd_pend,
        input  sensor,
        input  wr_data,
        output done
    );
endinterface

//////////////////////////////////////////////////
// read words, sequencer to serializer
//////////////////////////////////////////////////

interface word_if
    import cmd_pkg::*;
();
    logic  load;         // one cycle with word
    word_t word;
    logic  last;         // valid with load
    logic  next_word;

    modport source (
        output load,
        output word,
        output last,
        input  next_word
    );

    modport sink (
        input  load,
        input  word,
        input  last,
        output next_word
    );
endinterface

//--- verilog/tag_mem_top.sv
`timescale 1ns/1ps
`include "tag_mem_defines.svh"

module tag_mem_top
    import cmd_pkg::*;
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  adc_data_ready,
    input  logic [`TAG_ADC_W-1:0] adc_data,
    input  logic [`TAG_TS_W-1:0]  sensor_time_stamp,
    input  sensor_t               sensor_code,
    input  logic                  sensor_read,
    input  logic                  bit_tick,
    input  word_t                 mem_read_in,
    output word_t                 mem_data_out,
    output logic                  pc_b,
    output logic                  we,
    output logic                  se,
    output addr_t                 mem_address,
    output bank_t                 mem_sel,
    output logic                  mem_done,
    output logic                  tx_bit_src,
    output logic                  tx_data_done
);

    request_if u_request_if ();
    word_if    u_word_if ();

    sensor_request u_sensor_request (
        .clk               (clk),
        .reset             (reset),
        .adc_data_ready    (adc_data_ready),
        .adc_data          (adc_data),
        .sensor_time_stamp (sensor_time_stamp),
        .sensor_code       (sensor_code),
        .sensor_read       (sensor_read),
        .req               (u_request_if.source)
    );

    mem_sequencer u_mem_sequencer (
        .clk          (clk),
        .reset        (reset),
        .req          (u_request_if.sink),
        .tx           (u_word_if.source),
        .mem_read_in  (mem_read_in),
        .mem_data_out (mem_data_out),
        .pc_b         (pc_b),
        .we           (we),
        .se           (se),
        .mem_done     (mem_done),
        .mem_address  (mem_address),
        .mem_sel      (mem_sel)
    );

    tx_serializer u_tx_serializer (
        .clk          (clk),
        .reset        (reset),
        .bit_tick     (bit_tick),
        .tx           (u_word_if.sink),
        .tx_bit_src   (tx_bit_src),
        .tx_data_done (tx_data_done)
    );

endmodule

//--- verilog/tx_serializer.sv
`timescale 1ns/1ps
`include "tag_mem_defines.svh"

module tx_serializer
    import cmd_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    bit_tick,
    word_if.sink    tx,
    output logic    tx_bit_src,
    output logic    tx_data_done
);

    logic [3:0] bit_cnt;       // zero when no word is on the line
    word_t      shift_q;
    word_t      hold_q;        // next word, waits for the current one
    logic       hold_valid;
    logic       hold_last;
    logic       cur_last;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_cnt      <= '0;
            hold_valid   <= 1'b0;
            hold_last    <= 1'b0;
            cur_last     <= 1'b0;
            tx_bit_src   <= 1'b0;
            tx_data_done <= 1'b0;
            tx.next_word <= 1'b0;
        end else begin
            tx.next_word <= 1'b0;
            if (bit_tick) begin
                if (bit_cnt == '0) begin
                    if (hold_valid) begin
                        tx_bit_src <= hold_q[0];    // lsb first
                        cur_last   <= hold_last;
                        hold_valid <= 1'b0;
                        bit_cnt    <= 4'd1;
                    end
                end else begin
                    tx_bit_src <= shift_q[0];
                    bit_cnt    <= bit_cnt + 4'd1;    // wraps after bit 15
                    if (bit_cnt == 4'(`TAG_NEXT_BIT) && !cur_last) begin
                        tx.next_word <= 1'b1;
                    end
                    if (bit_cnt == 4'd15 && cur_last) begin
                        tx_data_done <= 1'b1;
                    end
                end
            end
            // a new word also opens a new read
            if (tx.load) begin
                hold_valid   <= 1'b1;
                hold_last    <= tx.last;
                tx_data_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx.load) begin
            hold_q <= tx.word;
        end
        if (bit_tick) begin
            shift_q <= (bit_cnt == '0) ? hold_q >> 1 : shift_q >> 1;
        end
    end

endmodule
